//--- hdl/hit_monitor_pkg.sv
// hit monitor package with channel counts, nominal pulse widths and shared word types
package hit_monitor_pkg;

	// channel counts
	localparam int HIT_CHANNELS  = 8; // synchronized hit lines from the front-end
	localparam int BUSY_CHANNELS = 2; // busy lines
	localparam int EVENT_LINES   = 4; // hit start, coincidence, logic match, ext trigger

	// nominal pulse widths in clocks, accepted window is width to width+2
	localparam int HIT_WIDTH  = 4; // 160 ns at 25 MHz
	localparam int BUSY_WIDTH = 4; // same window as hits

	// line vectors
	typedef logic [HIT_CHANNELS-1:0]  hit_vec_t;  // one bit per hit line
	typedef logic [BUSY_CHANNELS-1:0] busy_vec_t; // one bit per busy line

	// channel indices
	typedef logic [$clog2(HIT_CHANNELS)-1:0]  hit_sel_t;  // 3 bits
	typedef logic [$clog2(BUSY_CHANNELS)-1:0] busy_sel_t; // 1 bit

	// counter words
	typedef logic [31:0] monit_cnt_t; // monitored hit count
	typedef logic [15:0] event_cnt_t; // busy, event and trigger counts
	typedef logic [7:0]  err_cnt_t;   // saturating width error count
	typedef logic [2:0]  width_cnt_t; // high cycles seen by a width checker

endpackage

//--- hdl/monitor_control.sv
// monitor control: input edge detection, update-end edge and rotating hit channel selector
`timescale 1ns/1ps

module monitor_control (
	input  logic                       clk_in,
	input  logic                       rst_in,
	input  hit_monitor_pkg::hit_vec_t  hit_syn_in,            // synchronized hit lines
	input  hit_monitor_pkg::busy_vec_t busy_syn_in,           // synchronized busy lines
	input  logic                       update_end_in,         // end of remote monitor update
	input  hit_monitor_pkg::hit_sel_t  hit_monit_fix_sel_in,  // fixed hit channel
	input  hit_monitor_pkg::busy_sel_t busy_monit_fix_sel_in, // fixed busy channel
	output hit_monitor_pkg::hit_sel_t  hit_monit_sel,         // rotating hit channel
	output logic                       fix_hit_level,
	output logic                       fix_hit_edge,
	output logic                       rot_hit_level,
	output logic                       rot_hit_edge,
	output logic                       busy_level,
	output logic                       busy_edge
);

	hit_monitor_pkg::hit_vec_t  hit_r;     // hit lines one cycle ago
	hit_monitor_pkg::busy_vec_t busy_r;    // busy lines one cycle ago
	hit_monitor_pkg::hit_vec_t  hit_rise;  // leading edges of all hit lines
	hit_monitor_pkg::busy_vec_t busy_rise; // leading edges of all busy lines
	logic                       update_end_r;
	logic                       update_end_rise;

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			hit_r         <= '0;
			busy_r        <= '0;
			update_end_r  <= 1'b0;
			hit_monit_sel <= '0;
		end else begin
			hit_r        <= hit_syn_in;
			busy_r       <= busy_syn_in;
			update_end_r <= update_end_in;
			if (update_end_rise)
				hit_monit_sel <= hit_monit_sel + 1'b1; // next channel once the readout is done
		end
	end

	assign hit_rise        = hit_syn_in & ~hit_r;
	assign busy_rise       = busy_syn_in & ~busy_r;
	assign update_end_rise = update_end_in & ~update_end_r; // level may last several clocks

	// channel muxes
	assign fix_hit_level = hit_syn_in[hit_monit_fix_sel_in];
	assign fix_hit_edge  = hit_rise[hit_monit_fix_sel_in];
	assign rot_hit_level = hit_syn_in[hit_monit_sel];
	assign rot_hit_edge  = hit_rise[hit_monit_sel];
	assign busy_level    = busy_syn_in[busy_monit_fix_sel_in];
	assign busy_edge     = busy_rise[busy_monit_fix_sel_in];

	// the rotating channel moves only right after an update end
	a_sel_moves_on_update_end: assert property (@(posedge clk_in) disable iff (rst_in)
		!$stable(hit_monit_sel) |-> $past(update_end_rise))
		else $error("hit_monit_sel changed without an update_end rising edge");

endmodule

//--- hdl/pulse_width_checker.sv
// pulse width checker: idle/check FSM that flags a selected pulse shorter or longer than nominal
`timescale 1ns/1ps

module pulse_width_checker #(
	parameter int PULSE_WIDTH = hit_monitor_pkg::HIT_WIDTH // nominal width in clocks
) (
	input  logic clk_in,
	input  logic rst_in,
	input  logic level,         // selected line level
	input  logic pulse_edge,    // leading edge of the same line
	input  logic update_end_in, // aborts a running check
	output logic width_err      // one-cycle flag of a bad width
);

	logic                         checking;     // FSM state, high while a pulse is measured
	logic                         checking_nxt;
	hit_monitor_pkg::width_cnt_t  width_cnt;    // high cycles after the edge cycle
	logic                         too_long;
	logic                         too_short;

	// width_cnt holds N-1 for a pulse of N cycles when the line drops
	assign too_long  = (width_cnt > PULSE_WIDTH + 1);
	assign too_short = !level && (width_cnt < PULSE_WIDTH - 1);

	always_comb begin
		if (!checking) begin
			checking_nxt = pulse_edge && !update_end_in; // a line stuck high or low never starts
		end else begin
			// leave on update end, on an overlong pulse or when the pulse is over
			checking_nxt = !(update_end_in || too_long || !level);
		end
	end

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			checking  <= 1'b0;
			width_cnt <= '0;
			width_err <= 1'b0;
		end else begin
			checking <= checking_nxt;
			if (!checking) begin
				width_cnt <= '0;
				width_err <= 1'b0;
			end else begin
				if (level && !too_long)
					width_cnt <= width_cnt + 1'b1; // stops at PULSE_WIDTH+2
				// an update end overlapping the pulse masks the flag
				width_err <= !update_end_in && (too_long || too_short);
			end
		end
	end

	// the width counter stays inside its window
	a_width_cnt_bound: assert property (@(posedge clk_in) disable iff (rst_in)
		width_cnt <= PULSE_WIDTH + 2)
		else $error("width counter above PULSE_WIDTH+2");

endmodule

//--- hdl/monitor_counters.sv
// monitor counters: selected hit and busy edge counts and saturating width error counts
`timescale 1ns/1ps

module monitor_counters (
	input  logic                        clk_in,
	input  logic                        rst_in,
	input  logic                        update_end_in, // holds every counter at zero
	input  logic                        fix_hit_edge,
	input  logic                        rot_hit_edge,
	input  logic                        busy_edge,
	input  logic                        fix_hit_err,
	input  logic                        rot_hit_err,
	input  logic                        busy_err,
	output hit_monitor_pkg::monit_cnt_t hit_monit_cnt_0,    // fixed hit channel
	output hit_monitor_pkg::monit_cnt_t hit_monit_cnt_1,    // rotating hit channel
	output hit_monitor_pkg::event_cnt_t busy_monit_cnt,
	output hit_monitor_pkg::err_cnt_t   hit_monit_err_cnt,  // both hit checkers
	output hit_monitor_pkg::err_cnt_t   busy_monit_err_cnt
);

	logic hit_err; // either hit checker flagged this cycle

	assign hit_err = fix_hit_err || rot_hit_err; // coincident flags count once

	// edge counters
	always_ff @(posedge clk_in) begin
		if (rst_in || update_end_in) begin
			hit_monit_cnt_0 <= '0;
			hit_monit_cnt_1 <= '0;
			busy_monit_cnt  <= '0;
		end else begin
			if (fix_hit_edge)
				hit_monit_cnt_0 <= hit_monit_cnt_0 + 1'b1;
			if (rot_hit_edge)
				hit_monit_cnt_1 <= hit_monit_cnt_1 + 1'b1;
			if (busy_edge)
				busy_monit_cnt <= busy_monit_cnt + 1'b1; // wraps at 16 bits
		end
	end

	// width error counters, stop at full scale
	always_ff @(posedge clk_in) begin
		if (rst_in || update_end_in) begin
			hit_monit_err_cnt  <= '0;
			busy_monit_err_cnt <= '0;
		end else begin
			if (hit_err && (hit_monit_err_cnt != '1))
				hit_monit_err_cnt <= hit_monit_err_cnt + 1'b1;
			if (busy_err && (busy_monit_err_cnt != '1))
				busy_monit_err_cnt <= busy_monit_err_cnt + 1'b1;
		end
	end

endmodule

//--- hdl/tmr_trigger_counter.sv
// effective trigger counter: three redundant copies with bitwise majority vote and scrub
`timescale 1ns/1ps

module tmr_trigger_counter (
	input  logic                        clk_in,
	input  logic                        rst_in,
	input  logic                        eff_trg_in, // counted on every high cycle
	output hit_monitor_pkg::event_cnt_t eff_trg_cnt // voted count, doubles as trigger id
);

	hit_monitor_pkg::event_cnt_t cnt_a;
	hit_monitor_pkg::event_cnt_t cnt_b;
	hit_monitor_pkg::event_cnt_t cnt_c;
	hit_monitor_pkg::event_cnt_t cnt_vote; // bitwise majority of the copies
	logic                        copy_err; // copies disagree

	assign cnt_vote = (cnt_a & cnt_b) | (cnt_a & cnt_c) | (cnt_b & cnt_c);
	assign copy_err = (cnt_a != cnt_b) || (cnt_a != cnt_c);

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			cnt_a <= '0;
			cnt_b <= '0;
			cnt_c <= '0;
		end else if (eff_trg_in) begin
			cnt_a <= cnt_a + 1'b1;
			cnt_b <= cnt_b + 1'b1;
			cnt_c <= cnt_c + 1'b1;
		end else if (copy_err) begin
			cnt_a <= cnt_vote; // scrub a flipped copy between triggers
			cnt_b <= cnt_vote;
			cnt_c <= cnt_vote;
		end
	end

	// output register for timing
	always_ff @(posedge clk_in) begin
		if (rst_in)
			eff_trg_cnt <= '0;
		else
			eff_trg_cnt <= cnt_vote;
	end

	// a disagreement outside a trigger cycle is repaired in one clock
	a_scrub_repairs: assert property (@(posedge clk_in) disable iff (rst_in)
		copy_err && !eff_trg_in |=> !copy_err)
		else $error("trigger counter copies still differ after scrub");

endmodule

//--- hdl/event_counters.sv
// event counters: rising-edge counts of the four trigger-path strobes
`timescale 1ns/1ps

module event_counters (
	input  logic                        clk_in,
	input  logic                        rst_in,
	input  logic                        hit_start_in,
	input  logic                        coincid_trg_in,  // one clock wide
	input  logic                        logic_match_in,
	input  logic                        ext_trg_syn_in,
	output hit_monitor_pkg::event_cnt_t hit_start_cnt,
	output hit_monitor_pkg::event_cnt_t coincid_trg_cnt,
	output hit_monitor_pkg::event_cnt_t logic_match_cnt,
	output hit_monitor_pkg::event_cnt_t ext_trg_cnt
);

	logic [hit_monitor_pkg::EVENT_LINES-1:0] strobe;      // all strobes side by side
	logic [hit_monitor_pkg::EVENT_LINES-1:0] strobe_r;    // previous cycle
	logic [hit_monitor_pkg::EVENT_LINES-1:0] strobe_rise;
	hit_monitor_pkg::event_cnt_t             cnt [hit_monitor_pkg::EVENT_LINES];

	assign strobe      = {ext_trg_syn_in, logic_match_in, coincid_trg_in, hit_start_in};
	assign strobe_rise = strobe & ~strobe_r; // a held level counts once

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			strobe_r <= '0;
			for (int i = 0; i < hit_monitor_pkg::EVENT_LINES; i++)
				cnt[i] <= '0;
		end else begin
			strobe_r <= strobe;
			for (int i = 0; i < hit_monitor_pkg::EVENT_LINES; i++)
				if (strobe_rise[i])
					cnt[i] <= cnt[i] + 1'b1; // wraps at 16 bits
		end
	end

	assign hit_start_cnt   = cnt[0];
	assign coincid_trg_cnt = cnt[1];
	assign logic_match_cnt = cnt[2];
	assign ext_trg_cnt     = cnt[3];

endmodule

//--- hdl/hit_trigger_monitor.sv
// hit and trigger rate monitor top: control, width checkers and counter blocks
`timescale 1ns/1ps

module hit_trigger_monitor (
	input  logic                        clk_in,
	input  logic                        rst_in,
	input  hit_monitor_pkg::hit_vec_t   hit_syn_in,
	input  hit_monitor_pkg::busy_vec_t  busy_syn_in,
	input  logic                        hit_start_in,
	input  logic                        update_end_in,          // level, one or more clocks
	input  logic                        eff_trg_in,
	input  logic                        coincid_trg_in,
	input  logic                        logic_match_in,
	input  logic                        ext_trg_syn_in,
	input  hit_monitor_pkg::hit_sel_t   hit_monit_fix_sel_in,
	input  hit_monitor_pkg::busy_sel_t  busy_monit_fix_sel_in,
	output hit_monitor_pkg::hit_sel_t   hit_monit_sel_out,      // rotating channel now counted
	output hit_monitor_pkg::err_cnt_t   hit_monit_err_cnt_out,
	output hit_monitor_pkg::err_cnt_t   busy_monit_err_cnt_out,
	output hit_monitor_pkg::monit_cnt_t hit_monit_cnt_0_out,    // fixed channel hits
	output hit_monitor_pkg::monit_cnt_t hit_monit_cnt_1_out,    // rotating channel hits
	output hit_monitor_pkg::event_cnt_t busy_monit_cnt_out,
	output hit_monitor_pkg::event_cnt_t hit_start_cnt_out,
	output hit_monitor_pkg::event_cnt_t logic_match_cnt_out,
	output hit_monitor_pkg::event_cnt_t eff_trg_cnt_out,
	output hit_monitor_pkg::event_cnt_t coincid_trg_cnt_out,
	output hit_monitor_pkg::event_cnt_t ext_trg_cnt_out
);

	logic fix_hit_level;
	logic fix_hit_edge;
	logic rot_hit_level;
	logic rot_hit_edge;
	logic busy_level;
	logic busy_edge;
	logic fix_hit_err; // width flags from the three checkers
	logic rot_hit_err;
	logic busy_err;

	monitor_control i_monitor_control (
		.clk_in                (clk_in),
		.rst_in                (rst_in),
		.hit_syn_in            (hit_syn_in),
		.busy_syn_in           (busy_syn_in),
		.update_end_in         (update_end_in),
		.hit_monit_fix_sel_in  (hit_monit_fix_sel_in),
		.busy_monit_fix_sel_in (busy_monit_fix_sel_in),
		.hit_monit_sel         (hit_monit_sel_out),
		.fix_hit_level         (fix_hit_level),
		.fix_hit_edge          (fix_hit_edge),
		.rot_hit_level         (rot_hit_level),
		.rot_hit_edge          (rot_hit_edge),
		.busy_level            (busy_level),
		.busy_edge             (busy_edge)
	);

	pulse_width_checker #(.PULSE_WIDTH(hit_monitor_pkg::HIT_WIDTH)) i_fix_hit_checker (
		.clk_in        (clk_in),
		.rst_in        (rst_in),
		.level         (fix_hit_level),
		.pulse_edge    (fix_hit_edge),
		.update_end_in (update_end_in),
		.width_err     (fix_hit_err)
	);

	pulse_width_checker #(.PULSE_WIDTH(hit_monitor_pkg::HIT_WIDTH)) i_rot_hit_checker (
		.clk_in        (clk_in),
		.rst_in        (rst_in),
		.level         (rot_hit_level),
		.pulse_edge    (rot_hit_edge),
		.update_end_in (update_end_in), // also covers the selector step
		.width_err     (rot_hit_err)
	);

	pulse_width_checker #(.PULSE_WIDTH(hit_monitor_pkg::BUSY_WIDTH)) i_busy_checker (
		.clk_in        (clk_in),
		.rst_in        (rst_in),
		.level         (busy_level),
		.pulse_edge    (busy_edge),
		.update_end_in (update_end_in),
		.width_err     (busy_err)
	);

	monitor_counters i_monitor_counters (
		.clk_in             (clk_in),
		.rst_in             (rst_in),
		.update_end_in      (update_end_in),
		.fix_hit_edge       (fix_hit_edge),
		.rot_hit_edge       (rot_hit_edge),
		.busy_edge          (busy_edge),
		.fix_hit_err        (fix_hit_err),
		.rot_hit_err        (rot_hit_err),
		.busy_err           (busy_err),
		.hit_monit_cnt_0    (hit_monit_cnt_0_out),
		.hit_monit_cnt_1    (hit_monit_cnt_1_out),
		.busy_monit_cnt     (busy_monit_cnt_out),
		.hit_monit_err_cnt  (hit_monit_err_cnt_out),
		.busy_monit_err_cnt (busy_monit_err_cnt_out)
	);

	tmr_trigger_counter i_tmr_trigger_counter (
		.clk_in      (clk_in),
		.rst_in      (rst_in),
		.eff_trg_in  (eff_trg_in),
		.eff_trg_cnt (eff_trg_cnt_out)
	);

	event_counters i_event_counters (
		.clk_in          (clk_in),
		.rst_in          (rst_in),
		.hit_start_in    (hit_start_in),
		.coincid_trg_in  (coincid_trg_in),
		.logic_match_in  (logic_match_in),
		.ext_trg_syn_in  (ext_trg_syn_in),
		.hit_start_cnt   (hit_start_cnt_out),
		.coincid_trg_cnt (coincid_trg_cnt_out),
		.logic_match_cnt (logic_match_cnt_out),
		.ext_trg_cnt     (ext_trg_cnt_out)
	);

endmodule

//--- testbench/tb_hit_trigger_monitor.sv
// testbench for the hit and trigger rate monitor, driven by the test table in hit_monitor_tests.txt
`timescale 1ns/1ps

module tb_hit_trigger_monitor;

	localparam int    CLK_PERIOD     = 20;   // ns
	localparam int    RESET_CYCLES   = 4;
	localparam int    SETTLE_CYCLES  = 4;    // covers flag, error count and voted trigger latency
	localparam int    CYCLES_PER_TEST = 200; // watchdog budget
	localparam string TEST_FILE      = "testbench/hit_monitor_tests.txt";

	logic                        clk_in;
	logic                        rst_in;
	hit_monitor_pkg::hit_vec_t   hit_syn_in;
	hit_monitor_pkg::busy_vec_t  busy_syn_in;
	logic                        hit_start_in;
	logic                        update_end_in;
	logic                        eff_trg_in;
	logic                        coincid_trg_in;
	logic                        logic_match_in;
	logic                        ext_trg_syn_in;
	hit_monitor_pkg::hit_sel_t   hit_monit_fix_sel_in;
	hit_monitor_pkg::busy_sel_t  busy_monit_fix_sel_in;
	hit_monitor_pkg::hit_sel_t   hit_monit_sel_out;
	hit_monitor_pkg::err_cnt_t   hit_monit_err_cnt_out;
	hit_monitor_pkg::err_cnt_t   busy_monit_err_cnt_out;
	hit_monitor_pkg::monit_cnt_t hit_monit_cnt_0_out;
	hit_monitor_pkg::monit_cnt_t hit_monit_cnt_1_out;
	hit_monitor_pkg::event_cnt_t busy_monit_cnt_out;
	hit_monitor_pkg::event_cnt_t hit_start_cnt_out;
	hit_monitor_pkg::event_cnt_t logic_match_cnt_out;
	hit_monitor_pkg::event_cnt_t eff_trg_cnt_out;
	hit_monitor_pkg::event_cnt_t coincid_trg_cnt_out;
	hit_monitor_pkg::event_cnt_t ext_trg_cnt_out;

	string       op_q[$];        // test table columns
	int          ch_q[$];
	int          width_q[$];
	int          count_q[$];
	logic [31:0] exp_q[$];
	int          test_total  = 0;
	int          error_count = 0; // failed checks over the whole run
	int          failed_tests = 0;
	logic        test_bad;        // a check of the running test failed
	logic [31:0] lcg_state   = 32'h7672_1913;

	hit_trigger_monitor i_hit_trigger_monitor (.*);

	initial begin
		clk_in = 1'b0;
		forever #(CLK_PERIOD/2) clk_in = ~clk_in;
	end

	// numerical recipes constants
	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic report_mismatch(input string what, input longint got, input longint exp);
		$display("MISMATCH at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
		error_count++;
		test_bad = 1'b1;
	endtask

	task automatic check_monit(input hit_monitor_pkg::monit_cnt_t got,
		input hit_monitor_pkg::monit_cnt_t exp, input string what);
		if (got !== exp)
			report_mismatch(what, got, exp);
	endtask

	task automatic check_event(input hit_monitor_pkg::event_cnt_t got,
		input hit_monitor_pkg::event_cnt_t exp, input string what);
		if (got !== exp)
			report_mismatch(what, got, exp);
	endtask

	task automatic check_err(input hit_monitor_pkg::err_cnt_t got,
		input hit_monitor_pkg::err_cnt_t exp, input string what);
		if (got !== exp)
			report_mismatch(what, got, exp);
	endtask

	task automatic check_sel(input hit_monitor_pkg::hit_sel_t got,
		input hit_monitor_pkg::hit_sel_t exp, input string what);
		if (got !== exp)
			report_mismatch(what, got, exp);
	endtask

	// route one level to the line that an operation exercises
	task automatic set_line(input string op, input int ch, input logic val);
		case (op)
			"evt": case (ch)
				0:       hit_start_in   <= val;
				1:       coincid_trg_in <= val;
				2:       logic_match_in <= val;
				default: ext_trg_syn_in <= val;
			endcase
			"trg":               eff_trg_in <= val;
			"fix", "rot", "her": hit_syn_in[ch[2:0]] <= val;
			"ber", "bcn":        busy_syn_in[ch[0]] <= val;
			default:             update_end_in <= val; // upd
		endcase
	endtask

	// count pulses of width cycles with random low gaps of 2 to 6 cycles
	task automatic drive_pulses(input string op, input int ch, input int width, input int count);
		int gap;
		for (int p = 0; p < count; p++) begin
			@(posedge clk_in);
			set_line(op, ch, 1'b1);
			repeat (width) @(posedge clk_in); // high for exactly width samples
			set_line(op, ch, 1'b0);
			lcg_state = lcg_next(lcg_state);
			gap = 2 + int'(lcg_state[28:24]) % 5;
			repeat (gap - 1) @(posedge clk_in);
		end
	endtask

	task automatic check_result(input int idx);
		logic [31:0] exp;
		exp = exp_q[idx];
		case (op_q[idx])
			"evt": case (ch_q[idx])
				0:       check_event(hit_start_cnt_out, exp[15:0], "hit_start_cnt");
				1:       check_event(coincid_trg_cnt_out, exp[15:0], "coincid_trg_cnt");
				2:       check_event(logic_match_cnt_out, exp[15:0], "logic_match_cnt");
				default: check_event(ext_trg_cnt_out, exp[15:0], "ext_trg_cnt");
			endcase
			"trg": check_event(eff_trg_cnt_out, exp[15:0], "eff_trg_cnt");
			"fix": check_monit(hit_monit_cnt_0_out, exp, "hit_monit_cnt_0");
			"rot": check_monit(hit_monit_cnt_1_out, exp, "hit_monit_cnt_1");
			"her": check_err(hit_monit_err_cnt_out, exp[7:0], "hit_monit_err_cnt");
			"ber": check_err(busy_monit_err_cnt_out, exp[7:0], "busy_monit_err_cnt");
			"bcn": check_event(busy_monit_cnt_out, exp[15:0], "busy_monit_cnt");
			"upd": begin
				check_sel(hit_monit_sel_out, exp[2:0], "hit_monit_sel");
				check_monit(hit_monit_cnt_0_out, '0, "hit_monit_cnt_0 after update");
				check_monit(hit_monit_cnt_1_out, '0, "hit_monit_cnt_1 after update");
				check_event(busy_monit_cnt_out, '0, "busy_monit_cnt after update");
				check_err(hit_monit_err_cnt_out, '0, "hit_monit_err_cnt after update");
				check_err(busy_monit_err_cnt_out, '0, "busy_monit_err_cnt after update");
			end
			default: begin
				$display("test %0d has an unknown operation %s", idx + 1, op_q[idx]);
				error_count++;
				test_bad = 1'b1;
			end
		endcase
	endtask

	task automatic load_tests();
		int    fd;
		string line;
		string op;
		int    ch;
		int    width;
		int    count;
		logic [31:0] exp;
		fd = $fopen(TEST_FILE, "r");
		if (fd == 0) begin
			$display("cannot open the test table %s", TEST_FILE);
			error_count++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				if ($fgets(line, fd) == 0)
					continue;
				if (line.len() == 0 || line.getc(0) == "#")
					continue; // column description
				if ($sscanf(line, "%s %d %d %d %d", op, ch, width, count, exp) == 5) begin
					op_q.push_back(op);
					ch_q.push_back(ch);
					width_q.push_back(width);
					count_q.push_back(count);
					exp_q.push_back(exp);
				end
			end
			$fclose(fd);
			if (op_q.size() == 0) begin
				$display("the test table %s holds no tests", TEST_FILE);
				error_count++;
			end
		end
	endtask

	initial begin
		rst_in                <= 1'b1;
		hit_syn_in            <= '0;
		busy_syn_in           <= '0;
		hit_start_in          <= 1'b0;
		update_end_in         <= 1'b0;
		eff_trg_in            <= 1'b0;
		coincid_trg_in        <= 1'b0;
		logic_match_in        <= 1'b0;
		ext_trg_syn_in        <= 1'b0;
		hit_monit_fix_sel_in  <= 3'd2; // fixed hit channel for the whole run
		busy_monit_fix_sel_in <= 1'b1;
		test_bad              = 1'b0;
		load_tests();
		test_total = op_q.size(); // starts the watchdog
		repeat (RESET_CYCLES) @(posedge clk_in);
		rst_in <= 1'b0;
		for (int i = 0; i < test_total; i++) begin
			test_bad = 1'b0;
			drive_pulses(op_q[i], ch_q[i], width_q[i], count_q[i]);
			repeat (SETTLE_CYCLES) @(posedge clk_in);
			@(negedge clk_in); // outputs stable here
			check_result(i);
			if (test_bad)
				failed_tests++;
			$display("test %0d %s ch %0d width %0d x%0d: %s", i + 1, op_q[i], ch_q[i],
				width_q[i], count_q[i], test_bad ? "FAIL" : "pass");
		end
		$display("%0d tests run, %0d failed, %0d failed checks", test_total, failed_tests,
			error_count);
		if (error_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// watchdog sized from the test table length
	initial begin
		wait (test_total > 0);
		#((RESET_CYCLES + test_total * CYCLES_PER_TEST) * CLK_PERIOD);
		$display("watchdog expired, the tests did not complete in %0d cycles per test",
			CYCLES_PER_TEST);
		$display("Finished with errors");
		$finish;
	end

endmodule

//--- testbench/hit_monitor_tests.txt
# op ch width count expected, one test per line, decimal
# evt/trg/fix/rot/bcn expect a count, her/ber an error count, upd the selector
evt 0 1 5 5
evt 1 1 3 3
evt 2 6 4 4
evt 3 2 7 7
evt 0 3 2 7
trg 0 1 10 10
trg 0 5 3 25
fix 2 4 6 6
fix 5 4 3 6
rot 0 5 4 4
rot 3 5 2 4
her 2 2 3 3
her 2 6 2 3
her 2 7 2 5
her 0 1 1 6
her 2 8 1 7
ber 1 3 2 2
ber 1 5 3 2
ber 0 2 4 2
ber 1 9 1 3
bcn 1 4 4 10
upd 0 1 1 1
rot 1 4 3 3
her 1 3 2 2
upd 0 3 2 3
upd 0 1 5 0
fix 2 5 2 2
her 2 3 1 1

//--- verilog.f
hdl/hit_monitor_pkg.sv
hdl/monitor_control.sv
hdl/pulse_width_checker.sv
hdl/monitor_counters.sv
hdl/tmr_trigger_counter.sv
hdl/event_counters.sv
hdl/hit_trigger_monitor.sv
testbench/tb_hit_trigger_monitor.sv

//--- Makefile
# Verilator build and run for the hit and trigger rate monitor

VERILATOR ?= verilator
TOP       ?= tb_hit_trigger_monitor
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
